// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic arst_n
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // reset held over the first two rising edges
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule

// File: bench/retire_properties.sv
`timescale 1ns/1ps

module retire_properties
    import retire_pkg::*;
(
    input logic              clock,
    input logic              arst_n,
    input logic              flush,
    input logic              complete_valid,
    input rob_idx_t          complete_index,
    input rob_idx_t          rob_head,
    input logic [rob_sz-1:0] slot_valid,
    input logic              move_head,
    input bus_cmd_t          dmem_command
);

    // assertion failures so far
    int fail_count = 0;

    // a buffered completion must land in a free slot
    assert property (@(posedge clock) disable iff (!arst_n)
        (complete_valid && complete_index != rob_head) |-> !slot_valid[complete_index])
    else begin
        fail_count++;
        $error("completion wrote over a slot that still holds an entry");
    end

    // flush puts the head back at zero with nothing left to retire
    assert property (@(posedge clock) disable iff (!arst_n)
        flush |=> ((rob_head == '0) && !move_head))
    else begin
        fail_count++;
        $error("head not at zero or a retirement right after a flush");
    end

    // a store retirement moves the head on at the next edge
    assert property (@(posedge clock) disable iff (!arst_n)
        (dmem_command == bus_store) |=> (rob_head == $past(rob_head) + 1'b1))
    else begin
        fail_count++;
        $error("head did not advance after a store");
    end

endmodule

// File: bench/retire_tb.sv
`timescale 1ns/1ps

module retire_tb
    import retire_pkg::*;
;

    localparam int clk_period = 10;
    // summed cycle budget of reset and the five tests
    localparam int test_cycles = 4 + 40 + 40 + 20 + 20 + 40;

    logic       clock;
    logic       arst_n;
    logic       flush;
    logic       dispatch_valid;
    logic       dispatch_ready;
    rob_idx_t   dispatch_index;
    logic       complete_valid;
    rob_idx_t   complete_index;
    funit_t     complete_funit;
    mem_size_t  complete_mem_size;
    word_t      complete_result;
    word_t      complete_opb;
    word_t      complete_npc;
    word_t      complete_reg_data;
    logic       complete_illegal;
    logic       complete_halt;
    logic       complete_reg_en;
    reg_idx_t   complete_reg_idx;
    logic [3:0] mem_response;
    logic       commit_valid;
    logic       commit_reg_en;
    exc_code_t  commit_error;
    reg_idx_t   commit_reg_idx;
    word_t      commit_reg_data;
    word_t      commit_npc;
    bus_cmd_t   dmem_command;
    mem_size_t  dmem_size;
    word_t      dmem_addr;
    word_t      dmem_data;
    logic       rob_empty;

    // per index instruction record filled at dispatch
    funit_t     ins_funit   [rob_sz];
    mem_size_t  ins_size    [rob_sz];
    word_t      ins_result  [rob_sz];
    word_t      ins_opb     [rob_sz];
    word_t      ins_npc     [rob_sz];
    word_t      ins_data    [rob_sz];
    logic       ins_reg_en  [rob_sz];
    reg_idx_t   ins_reg_idx [rob_sz];
    logic       ins_illegal [rob_sz];
    logic       ins_halt    [rob_sz];
    logic [3:0] ins_resp    [rob_sz];

    // dispatched and not yet committed in program order
    rob_idx_t order_q[$];
    // indices of the latest dispatch batch
    rob_idx_t batch_q[$];
    // model of the tail pointer
    rob_idx_t next_index = '0;

    logic [31:0] lfsr = 32'h96cb;
    int          errors = 0;
    int          checks = 0;

    clock_gen i_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    retire_unit i_dut (.*);

    bind retire_buffer retire_properties i_props (
        .clock          (clock),
        .arst_n         (arst_n),
        .flush          (flush),
        .complete_valid (complete_valid),
        .complete_index (complete_index),
        .rob_head       (rob_head),
        .slot_valid     (slot_valid),
        .move_head      (move_head),
        .dmem_command   (dmem_command)
    );

    // galois lfsr stepped once per bit
    function automatic word_t lfsr_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // illegal beats halt which beats a faulting load
    function automatic exc_code_t expected_error(input rob_idx_t id);
        if (ins_illegal[id])
            return exc_illegal;
        else if (ins_halt[id])
            return exc_halt;
        else if (ins_funit[id] == funit_load && ins_resp[id] == 4'h0)
            return exc_load_fault;
        else
            return exc_none;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // n back to back dispatches with fresh alu records
    task automatic dispatch_batch(input int n);
        batch_q.delete();
        for (int k = 0; k < n; k++) begin
            @(posedge clock);
            dispatch_valid <= 1'b1;
            ins_funit[next_index]   = funit_alu;
            ins_size[next_index]    = mem_size_t'(lfsr_bits(2) % 3);
            ins_result[next_index]  = lfsr_bits(32);
            ins_opb[next_index]     = lfsr_bits(32);
            ins_npc[next_index]     = lfsr_bits(32);
            ins_data[next_index]    = lfsr_bits(32);
            ins_reg_en[next_index]  = 1'(lfsr_bits(1));
            ins_reg_idx[next_index] = reg_idx_t'(lfsr_bits(5));
            ins_illegal[next_index] = 1'b0;
            ins_halt[next_index]    = 1'b0;
            // nonzero response so no load fault by default
            ins_resp[next_index]    = 4'h8 | 4'(lfsr_bits(3));
            order_q.push_back(next_index);
            batch_q.push_back(next_index);
            next_index = next_index + 1'b1;
        end
        @(posedge clock);
        dispatch_valid <= 1'b0;
    endtask

    task automatic drive_completion(input rob_idx_t id);
        @(posedge clock);
        complete_valid    <= 1'b1;
        complete_index    <= id;
        complete_funit    <= ins_funit[id];
        complete_mem_size <= ins_size[id];
        complete_result   <= ins_result[id];
        complete_opb      <= ins_opb[id];
        complete_npc      <= ins_npc[id];
        complete_reg_data <= ins_data[id];
        complete_illegal  <= ins_illegal[id];
        complete_halt     <= ins_halt[id];
        complete_reg_en   <= ins_reg_en[id];
        complete_reg_idx  <= ins_reg_idx[id];
        mem_response      <= ins_resp[id];
    endtask

    task automatic idle_completion();
        @(posedge clock);
        complete_valid <= 1'b0;
    endtask

    // wait for the tracker to drain and then for the last commit
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        @(negedge clock);
        while (!rob_empty && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (!rob_empty) begin
            errors++;
            $display("rob_empty still low %0d cycles after the last completion", limit);
        end
        @(negedge clock);
        if (order_q.size() != 0) begin
            errors++;
            $display("%0d dispatched instructions never committed", order_q.size());
        end
    endtask

    // every completion hits the head and commits one cycle later
    task automatic in_order_test();
        dispatch_batch(8);
        foreach (batch_q[k]) begin
            drive_completion(batch_q[k]);
            idle_completion();
            @(negedge clock);
            check_value("commit_valid", 1, word_t'(commit_valid));
        end
        wait_drain(4);
    endtask

    task automatic out_of_order_test();
        rob_idx_t tmp;
        int       j;
        dispatch_batch(8);
        // fisher yates shuffle of the batch
        for (int k = 7; k > 0; k--) begin
            j = int'(lfsr_bits(4) % (k + 1));
            tmp = batch_q[k];
            batch_q[k] = batch_q[j];
            batch_q[j] = tmp;
        end
        foreach (batch_q[k]) begin
            drive_completion(batch_q[k]);
        end
        idle_completion();
        wait_drain(20);
    endtask

    // in order so each store retires in its completion cycle
    task automatic store_test();
        rob_idx_t id;
        dispatch_batch(4);
        ins_funit[batch_q[0]] = funit_store;
        ins_funit[batch_q[2]] = funit_store;
        foreach (batch_q[k]) begin
            id = batch_q[k];
            drive_completion(id);
            @(negedge clock);
            if (ins_funit[id] == funit_store) begin
                check_value("dmem_command", word_t'(bus_store), word_t'(dmem_command));
                check_value("dmem_addr", ins_result[id], dmem_addr);
                check_value("dmem_data", ins_opb[id], dmem_data);
                check_value("dmem_size", word_t'(ins_size[id]), word_t'(dmem_size));
            end else begin
                check_value("dmem_command", word_t'(bus_none), word_t'(dmem_command));
            end
        end
        idle_completion();
        wait_drain(4);
    endtask

    task automatic exception_test();
        dispatch_batch(4);
        // illegal beats halt
        ins_illegal[batch_q[0]] = 1'b1;
        ins_halt[batch_q[0]]    = 1'b1;
        // halt beats a faulting load
        ins_halt[batch_q[1]]    = 1'b1;
        ins_funit[batch_q[1]]   = funit_load;
        ins_resp[batch_q[1]]    = 4'h0;
        ins_funit[batch_q[2]]   = funit_load;
        ins_resp[batch_q[2]]    = 4'h0;
        // load with a good response
        ins_funit[batch_q[3]]   = funit_load;
        ins_resp[batch_q[3]]    = 4'h5;
        // reverse order so the buffered path carries the codes
        for (int k = 3; k >= 0; k--) begin
            drive_completion(batch_q[k]);
        end
        idle_completion();
        wait_drain(8);
    endtask

    task automatic flush_test();
        dispatch_batch(rob_sz);
        @(negedge clock);
        check_value("dispatch_ready", 0, word_t'(dispatch_ready));
        // head stays missing so nothing may retire
        drive_completion(batch_q[3]);
        drive_completion(batch_q[5]);
        // index 0 waits in its slot and is the head once the flush is done
        drive_completion(batch_q[8]);
        @(posedge clock);
        complete_valid <= 1'b0;
        flush          <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        order_q.delete();
        next_index = '0;
        repeat (4) begin
            @(negedge clock);
            check_value("commit_valid", 0, word_t'(commit_valid));
        end
        check_value("rob_empty", 1, word_t'(rob_empty));
        check_value("dispatch_index", word_t'(next_index), word_t'(dispatch_index));
    endtask

    // commit monitor checks fields against the oldest outstanding record
    always @(negedge clock) begin
        rob_idx_t id;
        if (arst_n && commit_valid) begin
            if (order_q.size() == 0) begin
                errors++;
                $display("commit_valid pulsed at %0t with nothing outstanding", $time);
            end else begin
                id = order_q.pop_front();
                check_value("commit_reg_idx", word_t'(ins_reg_idx[id]), word_t'(commit_reg_idx));
                check_value("commit_reg_data", ins_data[id], commit_reg_data);
                check_value("commit_npc", ins_npc[id], commit_npc);
                check_value("commit_reg_en", word_t'(ins_reg_en[id]), word_t'(commit_reg_en));
                check_value("commit_error", word_t'(expected_error(id)), word_t'(commit_error));
            end
        end
    end

    // run limit from the summed test budget
    initial begin
        #(test_cycles * clk_period);
        $display("watchdog expired, tests did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        flush             <= 1'b0;
        dispatch_valid    <= 1'b0;
        complete_valid    <= 1'b0;
        complete_index    <= '0;
        complete_funit    <= funit_alu;
        complete_mem_size <= mem_byte;
        complete_result   <= '0;
        complete_opb      <= '0;
        complete_npc      <= '0;
        complete_reg_data <= '0;
        complete_illegal  <= 1'b0;
        complete_halt     <= 1'b0;
        complete_reg_en   <= 1'b0;
        complete_reg_idx  <= '0;
        mem_response      <= 4'h0;
        @(posedge arst_n);
        @(negedge clock);
        // idle state out of reset
        check_value("commit_valid", 0, word_t'(commit_valid));
        check_value("move_head", 0, word_t'(i_dut.move_head));
        check_value("dmem_command", word_t'(bus_none), word_t'(dmem_command));
        check_value("rob_empty", 1, word_t'(rob_empty));
        check_value("dispatch_ready", 1, word_t'(dispatch_ready));
        in_order_test();
        out_of_order_test();
        store_test();
        exception_test();
        flush_test();
        errors = errors + i_dut.i_buffer.i_props.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
src/retire_pkg.sv
src/rob_tracker.sv
src/retire_buffer.sv
src/retire_unit.sv
bench/clock_gen.sv
bench/retire_properties.sv
bench/retire_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the retire unit testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module retire_tb -f list.f -o retire_sim

./obj_dir/retire_sim +verilator+error+limit+100 | tee sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    echo "run passed"
else
    echo "run failed"
    exit 1
fi

// File: src/retire_buffer.sv
`timescale 1ns/1ps

module retire_buffer
    import retire_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       flush,

    // head from the tracker
    input  rob_idx_t   rob_head,

    // completion from the execution units
    input  logic       complete_valid,
    input  rob_idx_t   complete_index,
    input  funit_t     complete_funit,
    input  mem_size_t  complete_mem_size,
    input  word_t      complete_result,
    input  word_t      complete_opb,
    input  word_t      complete_npc,
    input  word_t      complete_reg_data,
    input  logic       complete_illegal,
    input  logic       complete_halt,
    input  logic       complete_reg_en,
    input  reg_idx_t   complete_reg_idx,
    input  logic [3:0] mem_response,

    // back to the tracker
    output logic       move_head,

    // registered commit outputs
    output logic       commit_valid,
    output logic       commit_reg_en,
    output exc_code_t  commit_error,
    output reg_idx_t   commit_reg_idx,
    output word_t      commit_reg_data,
    output word_t      commit_npc,

    // data memory store port
    output bus_cmd_t   dmem_command,
    output mem_size_t  dmem_size,
    output word_t      dmem_addr,
    output word_t      dmem_data
);

    // exception status of the incoming completion
    exc_code_t in_error;

    // completion lands on the head this cycle
    logic do_forward;

    // per slot valid bits
    logic [rob_sz-1:0] slot_valid;

    // per slot payload
    funit_t    slot_funit    [rob_sz];
    mem_size_t slot_mem_size [rob_sz];
    word_t     slot_result   [rob_sz];
    word_t     slot_opb      [rob_sz];
    word_t     slot_npc      [rob_sz];
    word_t     slot_reg_data [rob_sz];
    logic      slot_reg_en   [rob_sz];
    reg_idx_t  slot_reg_idx  [rob_sz];
    exc_code_t slot_error    [rob_sz];

    // outgoing entry, forwarded or buffered head
    logic      out_valid;
    funit_t    out_funit;
    mem_size_t out_mem_size;
    word_t     out_result;
    word_t     out_opb;
    word_t     out_npc;
    word_t     out_reg_data;
    logic      out_reg_en;
    reg_idx_t  out_reg_idx;
    exc_code_t out_error;

    // classify by priority
    always_comb begin
        if (complete_illegal) begin
            in_error = exc_illegal;
        end else if (complete_halt) begin
            in_error = exc_halt;
        end else if (complete_funit == funit_load && mem_response == mem_resp_fault) begin
            in_error = exc_load_fault;
        end else begin
            in_error = exc_none;
        end
    end

    assign do_forward = complete_valid && (complete_index == rob_head);

    // pick the entry that retires this cycle
    always_comb begin
        if (do_forward) begin
            out_valid    = 1'b1;
            out_funit    = complete_funit;
            out_mem_size = complete_mem_size;
            out_result   = complete_result;
            out_opb      = complete_opb;
            out_npc      = complete_npc;
            out_reg_data = complete_reg_data;
            out_reg_en   = complete_reg_en;
            out_reg_idx  = complete_reg_idx;
            out_error    = in_error;
        end else begin
            out_valid    = slot_valid[rob_head];
            out_funit    = slot_funit[rob_head];
            out_mem_size = slot_mem_size[rob_head];
            out_result   = slot_result[rob_head];
            out_opb      = slot_opb[rob_head];
            out_npc      = slot_npc[rob_head];
            out_reg_data = slot_reg_data[rob_head];
            out_reg_en   = slot_reg_en[rob_head];
            out_reg_idx  = slot_reg_idx[rob_head];
            out_error    = slot_error[rob_head];
        end
    end

    // retire one per cycle, never while flushing
    assign move_head = out_valid && !flush;

    // store goes out in the retirement cycle
    assign dmem_command = (move_head && out_funit == funit_store) ? bus_store : bus_none;
    assign dmem_size    = out_mem_size;
    assign dmem_addr    = out_result;
    assign dmem_data    = out_opb;

    // valid bits: set on buffered completion, cleared on retire or flush
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
        end else if (flush) begin
            slot_valid <= '0;
        end else begin
            if (complete_valid && !do_forward) begin
                slot_valid[complete_index] <= 1'b1;
            end
            // forwarded head never sat in its slot
            if (move_head && !do_forward) begin
                slot_valid[rob_head] <= 1'b0;
            end
        end
    end

    // slot payload, written only for non forwarded completions
    always_ff @(posedge clock) begin
        if (complete_valid && !do_forward) begin
            slot_funit[complete_index]    <= complete_funit;
            slot_mem_size[complete_index] <= complete_mem_size;
            slot_result[complete_index]   <= complete_result;
            slot_opb[complete_index]      <= complete_opb;
            slot_npc[complete_index]      <= complete_npc;
            slot_reg_data[complete_index] <= complete_reg_data;
            slot_reg_en[complete_index]   <= complete_reg_en;
            slot_reg_idx[complete_index]  <= complete_reg_idx;
            slot_error[complete_index]    <= in_error;
        end
    end

    // commit pulse and status, one cycle after retirement
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid  <= 1'b0;
            commit_reg_en <= 1'b0;
            commit_error  <= exc_none;
        end else begin
            commit_valid <= move_head;
            if (move_head) begin
                commit_reg_en <= out_reg_en;
                commit_error  <= out_error;
            end
        end
    end

    // commit payload
    always_ff @(posedge clock) begin
        if (move_head) begin
            commit_reg_idx  <= out_reg_idx;
            commit_reg_data <= out_reg_data;
            commit_npc      <= out_npc;
        end
    end

endmodule

// File: src/retire_pkg.sv
package retire_pkg;

    // reorder buffer depth, kept a power of two so the pointers wrap on their own
    localparam int rob_sz = 16;

    // data path widths
    localparam int word_w    = 32;
    localparam int reg_idx_w = 5;

    // reorder index, one slot per entry
    typedef logic [$clog2(rob_sz)-1:0] rob_idx_t;

    // data word for results, operands and pcs
    typedef logic [word_w-1:0] word_t;

    // architectural destination register
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // functional unit class of a completed instruction
    typedef logic [1:0] funit_t;

    localparam funit_t funit_alu    = 2'd0;
    localparam funit_t funit_load   = 2'd1;
    localparam funit_t funit_store  = 2'd2;
    localparam funit_t funit_branch = 2'd3;

    // memory access size
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t mem_byte = 2'd0;
    localparam mem_size_t mem_half = 2'd1;
    localparam mem_size_t mem_word = 2'd2;

    // data memory command
    typedef logic [1:0] bus_cmd_t;

    localparam bus_cmd_t bus_none  = 2'd0;
    localparam bus_cmd_t bus_load  = 2'd1;
    localparam bus_cmd_t bus_store = 2'd2;

    // exception status reported at commit
    // priority: illegal, halt, load fault, none
    typedef logic [1:0] exc_code_t;

    localparam exc_code_t exc_none       = 2'd0;
    localparam exc_code_t exc_illegal    = 2'd1;
    localparam exc_code_t exc_halt       = 2'd2;
    localparam exc_code_t exc_load_fault = 2'd3;

    // load fault when the memory response tag is zero
    localparam logic [3:0] mem_resp_fault = 4'h0;

endpackage

// File: src/retire_unit.sv
`timescale 1ns/1ps

module retire_unit
    import retire_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       flush,

    // dispatch
    input  logic       dispatch_valid,
    output logic       dispatch_ready,
    output rob_idx_t   dispatch_index,

    // completion
    input  logic       complete_valid,
    input  rob_idx_t   complete_index,
    input  funit_t     complete_funit,
    input  mem_size_t  complete_mem_size,
    input  word_t      complete_result,
    input  word_t      complete_opb,
    input  word_t      complete_npc,
    input  word_t      complete_reg_data,
    input  logic       complete_illegal,
    input  logic       complete_halt,
    input  logic       complete_reg_en,
    input  reg_idx_t   complete_reg_idx,
    input  logic [3:0] mem_response,

    // commit
    output logic       commit_valid,
    output logic       commit_reg_en,
    output exc_code_t  commit_error,
    output reg_idx_t   commit_reg_idx,
    output word_t      commit_reg_data,
    output word_t      commit_npc,

    // data memory
    output bus_cmd_t   dmem_command,
    output mem_size_t  dmem_size,
    output word_t      dmem_addr,
    output word_t      dmem_data,

    output logic       rob_empty
);

    // head handshake between tracker and buffer
    rob_idx_t rob_head;
    logic     move_head;

    rob_tracker i_tracker (
        .clock          (clock),
        .arst_n         (arst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_index (dispatch_index),
        .move_head      (move_head),
        .rob_head       (rob_head),
        .rob_empty      (rob_empty)
    );

    retire_buffer i_buffer (
        .clock             (clock),
        .arst_n            (arst_n),
        .flush             (flush),
        .rob_head          (rob_head),
        .complete_valid    (complete_valid),
        .complete_index    (complete_index),
        .complete_funit    (complete_funit),
        .complete_mem_size (complete_mem_size),
        .complete_result   (complete_result),
        .complete_opb      (complete_opb),
        .complete_npc      (complete_npc),
        .complete_reg_data (complete_reg_data),
        .complete_illegal  (complete_illegal),
        .complete_halt     (complete_halt),
        .complete_reg_en   (complete_reg_en),
        .complete_reg_idx  (complete_reg_idx),
        .mem_response      (mem_response),
        .move_head         (move_head),
        .commit_valid      (commit_valid),
        .commit_reg_en     (commit_reg_en),
        .commit_error      (commit_error),
        .commit_reg_idx    (commit_reg_idx),
        .commit_reg_data   (commit_reg_data),
        .commit_npc        (commit_npc),
        .dmem_command      (dmem_command),
        .dmem_size         (dmem_size),
        .dmem_addr         (dmem_addr),
        .dmem_data         (dmem_data)
    );

endmodule

// File: src/rob_tracker.sv
`timescale 1ns/1ps

module rob_tracker
    import retire_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  logic     flush,

    // dispatch side
    input  logic     dispatch_valid,
    output logic     dispatch_ready,
    output rob_idx_t dispatch_index,

    // retire side
    input  logic     move_head,
    output rob_idx_t rob_head,
    output logic     rob_empty
);

    // occupancy runs 0 to rob_sz, so one bit wider than an index
    logic [$clog2(rob_sz):0] count;

    rob_idx_t head;
    rob_idx_t tail;

    logic dispatch_fire;

    // a dispatch only lands when there is room
    assign dispatch_fire = dispatch_valid && dispatch_ready;

    // full and empty straight from the count
    assign dispatch_ready = (count != rob_sz);
    assign rob_empty      = (count == '0);

    // next index handed out is the tail
    assign dispatch_index = tail;
    assign rob_head       = head;

    // tail pointer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tail <= '0;
        end else if (flush) begin
            tail <= '0;
        end else if (dispatch_fire) begin
            // power of two depth, plain increment wraps
            tail <= tail + 1'b1;
        end
    end

    // head pointer, moved by the retire buffer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
        end else if (flush) begin
            head <= '0;
        end else if (move_head) begin
            head <= head + 1'b1;
        end
    end

    // occupancy
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            case ({dispatch_fire, move_head})
                // dispatch only
                2'b10: begin
                    count <= count + 1'b1;
                end
                // retire only
                2'b01: begin
                    count <= count - 1'b1;
                end
                // both or neither, no change
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule
